//--- ex_unit.f
ex_pkg.sv
ex_alu.sv
ex_mult.sv
ex_div.sv
ex_issue_reg.sv
ex_stage.sv
ex_top.sv
ex_properties.sv
ex_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -Wno-fatal -j 0
TOP       := ex_tb
FILELIST  := ex_unit.f
BUILD_DIR := obj_dir

SOURCES   := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- ex_tb.sv
//////////////////////////////////////////////////////////////////////
// Random-stimulus testbench for the execute subsystem
// Reference model results queued per accepted operation
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module ex_tb;
  import ex_pkg::*;

  localparam int unsigned tag_w          = 5;
  localparam int unsigned n_random       = 400;
  localparam int          timeout_cycles = 1000;

  logic                 clk;
  logic                 rst_n;
  logic                 in_valid_i;
  logic                 in_ready_o;
  unit_e                in_unit_i;
  logic [op_code_w-1:0] in_op_i;
  logic [data_w-1:0]    in_a_i;
  logic [data_w-1:0]    in_b_i;
  logic [tag_w-1:0]     in_tag_i;
  logic                 wb_valid_o;
  logic [tag_w-1:0]     wb_tag_o;
  logic [data_w-1:0]    wb_data_o;
  logic                 wb_ready_i;

  integer               seed;
  logic                 bp_en;
  logic [tag_w-1:0]     next_tag;
  // Expected {tag, data} in issue order
  logic [tag_w+31:0]    exp_q[$];

  ex_top #(.tag_w(tag_w)) dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_unit_i  (in_unit_i),
    .in_op_i    (in_op_i),
    .in_a_i     (in_a_i),
    .in_b_i     (in_b_i),
    .in_tag_i   (in_tag_i),
    .wb_valid_o (wb_valid_o),
    .wb_tag_o   (wb_tag_o),
    .wb_data_o  (wb_data_o),
    .wb_ready_i (wb_ready_i)
  );

  bind ex_top ex_properties #(.tag_w(tag_w)) u_properties (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid_i (in_valid_i),
    .in_ready_i (in_ready_o),
    .in_unit_i  (in_unit_i),
    .in_op_i    (in_op_i),
    .in_a_i     (in_a_i),
    .in_b_i     (in_b_i),
    .in_tag_i   (in_tag_i),
    .wb_valid_i (wb_valid_o),
    .wb_tag_i   (wb_tag_o),
    .wb_data_i  (wb_data_o),
    .wb_ready_i (wb_ready_i)
  );

  // 40 ns clock
  always #20 clk = ~clk;

  task automatic fail_run(string reason);
    $display("ERROR: %s at %0t", reason, $time);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
    if (got !== expected) begin
      $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, expected);
      fail_run({"wrong value on ", name});
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model, RISC-V integer rules
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] expected_result(unit_e unit, logic [3:0] op,
                                                  logic [31:0] a, logic [31:0] b);
    logic [63:0] a_ext;
    logic [63:0] b_ext;
    logic [63:0] prod;
    logic        ovf;
    logic [31:0] res;
    a_ext = {32'h0, a};
    b_ext = {32'h0, b};
    ovf   = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    res   = '0;
    case (unit)
      UNIT_MUL: begin
        // mulh sign-extends both, mulhsu only a
        if (op[1:0] == MUL_HSS || op[1:0] == MUL_HSU) begin
          a_ext = {{32{a[31]}}, a};
        end
        if (op[1:0] == MUL_HSS) begin
          b_ext = {{32{b[31]}}, b};
        end
        prod = a_ext * b_ext;
        res  = (op[1:0] == MUL_LO) ? prod[31:0] : prod[63:32];
      end
      UNIT_DIV: begin
        // op[1] picks remainder, op[0] unsigned
        if (b == 32'h0) begin
          res = op[1] ? a : 32'hffff_ffff;
        end else if (ovf && !op[0]) begin
          res = op[1] ? 32'h0 : a;
        end else begin
          case (div_op_e'(op[1:0]))
            DIV_S:   res = $signed(a) / $signed(b);
            DIV_U:   res = a / b;
            REM_S:   res = $signed(a) % $signed(b);
            default: res = a % b;
          endcase
        end
      end
      default: begin
        case (alu_op_e'(op))
          ALU_ADD: res = a + b;
          ALU_SUB: res = a - b;
          ALU_AND: res = a & b;
          ALU_OR:  res = a | b;
          ALU_XOR: res = a ^ b;
          ALU_SLL: res = a << b[4:0];
          ALU_SRL: res = a >> b[4:0];
          ALU_SRA: res = $signed(a) >>> b[4:0];
          ALU_SLT: res = {31'h0, $signed(a) < $signed(b)};
          default: res = {31'h0, a < b};
        endcase
      end
    endcase
    return res;
  endfunction

  // Corner values often, small values for long divides
  function automatic logic [31:0] random_operand();
    int pick;
    pick = $unsigned($random(seed)) % 8;
    case (pick)
      0:       return 32'h0;
      1:       return 32'h8000_0000;
      2:       return 32'hffff_ffff;
      3:       return 32'($unsigned($random(seed)) % 32);
      default: return $random(seed);
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Entered 2 ns after a rising edge, left the same way
  task automatic send_op(unit_e unit, logic [3:0] op, logic [31:0] a, logic [31:0] b);
    int waited;
    in_valid_i = 1'b1;
    in_unit_i  = unit;
    in_op_i    = op;
    in_a_i     = a;
    in_b_i     = b;
    in_tag_i   = next_tag;
    waited     = 0;
    @(negedge clk);
    while (!in_ready_o) begin
      if (waited > timeout_cycles) begin
        fail_run("operation never accepted, in_ready_o stuck low");
      end else begin
        waited++;
        @(negedge clk);
      end
    end
    // Transfer happens on the coming rising edge
    exp_q.push_back({in_tag_i, expected_result(unit, op, a, b)});
    next_tag++;
    @(posedge clk);
    #2;
    in_valid_i = 1'b0;
  endtask

  task automatic send_random_op();
    unit_e      unit;
    logic [3:0] op;
    int         gap;
    gap = $unsigned($random(seed)) % 3;
    repeat (gap) begin
      @(posedge clk);
      #2;
    end
    unit = unit_e'($unsigned($random(seed)) % 3);
    if (unit == UNIT_ALU) begin
      op = 4'($unsigned($random(seed)) % 10);
    end else begin
      op = 4'($unsigned($random(seed)) % 4);
    end
    send_op(unit, op, random_operand(), random_operand());
  endtask

  task automatic run_directed();
    for (int i = 0; i < 10; i++) begin
      send_op(UNIT_ALU, 4'(i), 32'hf0f0_1234, 32'h8000_0007);
    end
    // Shift amount extremes, signed against unsigned compare
    send_op(UNIT_ALU, ALU_SLL, 32'h8000_0001, 32'd0);
    send_op(UNIT_ALU, ALU_SLL, 32'h8000_0001, 32'd31);
    send_op(UNIT_ALU, ALU_SRL, 32'h8000_0001, 32'd31);
    send_op(UNIT_ALU, ALU_SRA, 32'h8000_0001, 32'd31);
    send_op(UNIT_ALU, ALU_SRA, 32'h8000_0001, 32'd0);
    send_op(UNIT_ALU, ALU_SLT, 32'hffff_ffff, 32'd1);
    send_op(UNIT_ALU, ALU_SLTU, 32'hffff_ffff, 32'd1);
    for (int i = 0; i < 4; i++) begin
      send_op(UNIT_MUL, 4'(i), 32'h8000_0000, 32'hffff_ffff);
      send_op(UNIT_MUL, 4'(i), 32'h8000_0000, 32'h8000_0000);
      send_op(UNIT_MUL, 4'(i), 32'hffff_ffff, 32'hffff_ffff);
      send_op(UNIT_DIV, 4'(i), 32'h1234_5678, 32'h0);
      send_op(UNIT_DIV, 4'(i), 32'h8000_0000, 32'hffff_ffff);
      // Long divide with a short ALU op right behind
      send_op(UNIT_DIV, 4'(i), 32'hffff_fff0, 32'd3);
      send_op(UNIT_ALU, ALU_XOR, 32'h5a5a_5a5a, 32'(i));
    end
  endtask

  // Counts falling edges from acceptance to first wb_valid_o
  task automatic measure_latency(unit_e unit, logic [3:0] op, int expected);
    int lat;
    send_op(unit, op, random_operand(), random_operand());
    lat = 1;
    @(negedge clk);
    while (!wb_valid_o) begin
      if (lat > timeout_cycles) begin
        fail_run("no result after a single operation");
      end else begin
        lat++;
        @(negedge clk);
      end
    end
    check_value("latency", 32'(lat), 32'(expected));
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited > timeout_cycles) begin
        fail_run("results still outstanding after timeout");
      end else begin
        waited++;
        @(posedge clk);
      end
    end
  endtask

  // Writeback back-pressure, low on about 30% of cycles
  always @(posedge clk) begin
    #2;
    if (bp_en) begin
      wb_ready_i = ($unsigned($random(seed)) % 10) >= 3;
    end else begin
      wb_ready_i = 1'b1;
    end
  end

  // Result monitor, sampled mid-cycle
  always @(negedge clk) begin : monitor
    logic [tag_w+31:0] entry;
    if (rst_n && wb_valid_o && wb_ready_i) begin
      if (exp_q.size() == 0) begin
        fail_run("result arrived with no operation outstanding");
      end else begin
        entry = exp_q.pop_front();
        check_value("wb_tag_o", 32'(wb_tag_o), 32'(entry[tag_w+31:32]));
        check_value("wb_data_o", wb_data_o, entry[31:0]);
      end
    end
  end

  initial begin
    seed       = 32'hd8;
    clk        = 1'b0;
    rst_n      = 1'b0;
    in_valid_i = 1'b0;
    in_unit_i  = UNIT_ALU;
    in_op_i    = '0;
    in_a_i     = '0;
    in_b_i     = '0;
    in_tag_i   = '0;
    wb_ready_i = 1'b1;
    bp_en      = 1'b0;
    next_tag   = '0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("wb_valid_o", 32'(wb_valid_o), 32'h0);
    check_value("in_ready_o", 32'(in_ready_o), 32'h1);
    @(posedge clk);
    #2;
    // Fixed latencies with writeback always ready
    measure_latency(UNIT_ALU, ALU_ADD, 2);
    wait_drained();
    @(posedge clk);
    #2;
    measure_latency(UNIT_MUL, MUL_HSS, 3);
    wait_drained();
    @(posedge clk);
    #2;
    bp_en = 1'b1;
    run_directed();
    for (int i = 0; i < n_random; i++) begin
      send_random_op();
    end
    wait_drained();
    // Quiet window longer than the slowest divide lets a stray result reach the monitor
    bp_en = 1'b0;
    repeat (40) begin
      @(negedge clk);
    end
    if (wb_valid_o !== 1'b0) begin
      fail_run("result still offered after all operations were drained");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

//--- ex_properties.sv
//////////////////////////////////////////////////////////////////////
// Handshake checks on the execute subsystem ports
// Attached to ex_top by bind from the testbench
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module ex_properties #(
  parameter int unsigned tag_w = 5
) (
  input logic                          clk,
  input logic                          rst_n,
  // Operation source side
  input logic                          in_valid_i,
  input logic                          in_ready_i,
  input ex_pkg::unit_e                 in_unit_i,
  input logic [ex_pkg::op_code_w-1:0]  in_op_i,
  input logic [ex_pkg::data_w-1:0]     in_a_i,
  input logic [ex_pkg::data_w-1:0]     in_b_i,
  input logic [tag_w-1:0]              in_tag_i,
  // Writeback side
  input logic                          wb_valid_i,
  input logic [tag_w-1:0]              wb_tag_i,
  input logic [ex_pkg::data_w-1:0]     wb_data_i,
  input logic                          wb_ready_i
);

  // Waiting operation stays offered and unchanged
  property in_held;
    @(posedge clk) disable iff (!rst_n)
      in_valid_i && !in_ready_i |=>
        in_valid_i && $stable({in_unit_i, in_op_i, in_a_i, in_b_i, in_tag_i});
  endproperty

  // Stalled result keeps its tag and data
  property wb_held;
    @(posedge clk) disable iff (!rst_n)
      wb_valid_i && !wb_ready_i |=>
        wb_valid_i && $stable(wb_tag_i) && $stable(wb_data_i);
  endproperty

  // No X on the outputs once out of reset
  property outputs_known;
    @(posedge clk) disable iff (!rst_n)
      !$isunknown({in_ready_i, wb_valid_i, wb_tag_i, wb_data_i});
  endproperty

  a_in_held: assert property (in_held)
    else $error("operation withdrawn or changed before acceptance");
  a_wb_held: assert property (wb_held)
    else $error("stalled result withdrawn or changed");
  a_outputs_known: assert property (outputs_known)
    else $error("unknown value on an output after reset");

endmodule

//--- ex_top.sv
//////////////////////////////////////////////////////////////////////
// Execute subsystem top, issue register feeding the execute stage
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module ex_top #(
  parameter int unsigned tag_w = 5
) (
  input  logic                          clk,
  input  logic                          rst_n,
  // Decoded operation in
  input  logic                          in_valid_i,
  output logic                          in_ready_o,
  input  ex_pkg::unit_e                 in_unit_i,
  input  logic [ex_pkg::op_code_w-1:0]  in_op_i,
  input  logic [ex_pkg::data_w-1:0]     in_a_i,
  input  logic [ex_pkg::data_w-1:0]     in_b_i,
  input  logic [tag_w-1:0]              in_tag_i,
  // Result out
  output logic                          wb_valid_o,
  output logic [tag_w-1:0]              wb_tag_o,
  output logic [ex_pkg::data_w-1:0]     wb_data_o,
  input  logic                          wb_ready_i
);

  logic                         id_ex_valid;
  ex_pkg::unit_e                id_ex_unit;
  logic [ex_pkg::op_code_w-1:0] id_ex_op;
  logic [ex_pkg::data_w-1:0]    id_ex_opa;
  logic [ex_pkg::data_w-1:0]    id_ex_opb;
  logic [tag_w-1:0]             id_ex_tag;
  logic                         ex_ready;

  ex_issue_reg #(.tag_w(tag_w)) u_issue (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_unit_i  (in_unit_i),
    .in_op_i    (in_op_i),
    .in_a_i     (in_a_i),
    .in_b_i     (in_b_i),
    .in_tag_i   (in_tag_i),
    .ex_ready_i (ex_ready),
    .valid_o    (id_ex_valid),
    .unit_o     (id_ex_unit),
    .op_o       (id_ex_op),
    .opa_o      (id_ex_opa),
    .opb_o      (id_ex_opb),
    .tag_o      (id_ex_tag)
  );

  ex_stage #(.tag_w(tag_w)) u_ex (
    .clk           (clk),
    .rst_n         (rst_n),
    .id_ex_valid_i (id_ex_valid),
    .id_ex_unit_i  (id_ex_unit),
    .id_ex_op_i    (id_ex_op),
    .id_ex_opa_i   (id_ex_opa),
    .id_ex_opb_i   (id_ex_opb),
    .id_ex_tag_i   (id_ex_tag),
    .ex_ready_o    (ex_ready),
    .wb_valid_o    (wb_valid_o),
    .wb_tag_o      (wb_tag_o),
    .wb_data_o     (wb_data_o),
    .wb_ready_i    (wb_ready_i)
  );

endmodule

//--- ex_stage.sv
//////////////////////////////////////////////////////////////////////
// Execute stage with ALU, multiplier, divider and EX/WB register
// Operation stays in ID/EX until its result enters EX/WB
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module ex_stage #(
  parameter int unsigned tag_w = 5
) (
  input  logic                          clk,
  input  logic                          rst_n,
  // ID/EX
  input  logic                          id_ex_valid_i,
  input  ex_pkg::unit_e                 id_ex_unit_i,
  input  logic [ex_pkg::op_code_w-1:0]  id_ex_op_i,
  input  logic [ex_pkg::data_w-1:0]     id_ex_opa_i,
  input  logic [ex_pkg::data_w-1:0]     id_ex_opb_i,
  input  logic [tag_w-1:0]              id_ex_tag_i,
  output logic                          ex_ready_o,
  // EX/WB towards writeback
  output logic                          wb_valid_o,
  output logic [tag_w-1:0]              wb_tag_o,
  output logic [ex_pkg::data_w-1:0]     wb_data_o,
  input  logic                          wb_ready_i
);
  import ex_pkg::*;

  logic [data_w-1:0] alu_result;
  logic [data_w-1:0] mul_result;
  logic [data_w-1:0] div_result;
  logic              mul_en_gated;
  logic              div_en_gated;
  logic              mul_valid;
  logic              mul_ready;
  logic              div_valid;
  logic              div_ready;
  logic              div_clz_en;
  logic [data_w-1:0] div_clz_data;
  logic [clz_w-1:0]  div_clz_result;
  logic              div_shift_en;
  logic [clz_w-1:0]  div_shift_amt;
  logic [data_w-1:0] div_shifted;
  logic              wb_ready;
  logic              unit_valid;
  logic              ex_valid;
  logic [data_w-1:0] ex_result;

  // Multiply is issued once, a held product belongs to this op
  assign mul_en_gated = id_ex_valid_i && (id_ex_unit_i == UNIT_MUL) && !mul_valid;
  assign div_en_gated = id_ex_valid_i && (id_ex_unit_i == UNIT_DIV);

  // EX/WB can load when empty or draining
  assign wb_ready = wb_ready_i || !wb_valid_o;

  ex_alu u_alu (
    .operator_i   (alu_op_e'(id_ex_op_i)),
    .operand_a_i  (id_ex_opa_i),
    .operand_b_i  (id_ex_opb_i),
    .clz_en_i     (div_clz_en),
    .clz_data_i   (div_clz_data),
    .clz_result_o (div_clz_result),
    .shift_en_i   (div_shift_en),
    .shift_amt_i  (div_shift_amt),
    .shifted_o    (div_shifted),
    .result_o     (alu_result)
  );

  ex_mult u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .operator_i (mul_op_e'(id_ex_op_i[1:0])),
    .op_a_i     (id_ex_opa_i),
    .op_b_i     (id_ex_opb_i),
    .result_o   (mul_result),
    .valid_i    (mul_en_gated),
    .ready_o    (mul_ready),
    .valid_o    (mul_valid),
    .ready_i    (wb_ready)
  );

  // Operands arrive swapped, opb is the dividend
  ex_div u_div (
    .clk              (clk),
    .rst_n            (rst_n),
    .operator_i       (div_op_e'(id_ex_op_i[1:0])),
    .op_a_i           (id_ex_opb_i),
    .op_b_i           (id_ex_opa_i),
    .alu_clz_result_i (div_clz_result),
    .alu_clz_en_o     (div_clz_en),
    .alu_clz_data_o   (div_clz_data),
    .alu_shifted_i    (div_shifted),
    .alu_shift_en_o   (div_shift_en),
    .alu_shift_amt_o  (div_shift_amt),
    .result_o         (div_result),
    .valid_i          (div_en_gated),
    .ready_o          (div_ready),
    .valid_o          (div_valid),
    .ready_i          (wb_ready)
  );

  // Result and valid of the selected unit, ALU always valid
  always_comb begin
    case (id_ex_unit_i)
      UNIT_MUL: begin
        unit_valid = mul_valid;
        ex_result  = mul_result;
      end
      UNIT_DIV: begin
        unit_valid = div_valid;
        ex_result  = div_result;
      end
      default: begin
        unit_valid = 1'b1;
        ex_result  = alu_result;
      end
    endcase
  end

  assign ex_valid   = id_ex_valid_i && unit_valid;
  assign ex_ready_o = !id_ex_valid_i || (ex_valid && wb_ready && mul_ready && div_ready);

  //////////////////////////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o <= 1'b0;
      wb_tag_o   <= '0;
      wb_data_o  <= '0;
    end else if (ex_valid && wb_ready) begin
      wb_valid_o <= 1'b1;
      wb_tag_o   <= id_ex_tag_i;
      wb_data_o  <= ex_result;
    end else if (wb_ready) begin
      // Nothing to pass on, insert a bubble
      wb_valid_o <= 1'b0;
    end
  end

endmodule

//--- ex_issue_reg.sv
//////////////////////////////////////////////////////////////////////
// ID/EX register holding one decoded operation from outside
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module ex_issue_reg #(
  parameter int unsigned tag_w = 5
) (
  input  logic                          clk,
  input  logic                          rst_n,
  // Operation source
  input  logic                          in_valid_i,
  output logic                          in_ready_o,
  input  ex_pkg::unit_e                 in_unit_i,
  input  logic [ex_pkg::op_code_w-1:0]  in_op_i,
  input  logic [ex_pkg::data_w-1:0]     in_a_i,
  input  logic [ex_pkg::data_w-1:0]     in_b_i,
  input  logic [tag_w-1:0]              in_tag_i,
  // Towards the execute stage
  input  logic                          ex_ready_i,
  output logic                          valid_o,
  output ex_pkg::unit_e                 unit_o,
  output logic [ex_pkg::op_code_w-1:0]  op_o,
  output logic [ex_pkg::data_w-1:0]     opa_o,
  output logic [ex_pkg::data_w-1:0]     opb_o,
  output logic [tag_w-1:0]              tag_o
);
  import ex_pkg::*;

  // Empty, or the current op is consumed this cycle
  assign in_ready_o = !valid_o || ex_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_o <= 1'b0;
    end else if (in_ready_o) begin
      valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      unit_o <= in_unit_i;
      op_o   <= in_op_i;
      tag_o  <= in_tag_i;
      // Divisor goes to operand a, the ALU shifter input
      opa_o  <= (in_unit_i == UNIT_DIV) ? in_b_i : in_a_i;
      opb_o  <= (in_unit_i == UNIT_DIV) ? in_a_i : in_b_i;
    end
  end

endmodule

//--- ex_div.sv
//////////////////////////////////////////////////////////////////////
// Iterative shift-subtract divider, one quotient bit per cycle
// Divisor is normalised with the ALU's counter and shifter
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module ex_div (
  input  logic                       clk,
  input  logic                       rst_n,
  input  ex_pkg::div_op_e            operator_i,
  // Dividend and divisor
  input  logic [ex_pkg::data_w-1:0]  op_a_i,
  input  logic [ex_pkg::data_w-1:0]  op_b_i,
  // Borrowed ALU counter
  input  logic [ex_pkg::clz_w-1:0]   alu_clz_result_i,
  output logic                       alu_clz_en_o,
  output logic [ex_pkg::data_w-1:0]  alu_clz_data_o,
  // Borrowed ALU shifter, shifts the divisor on ALU operand a
  input  logic [ex_pkg::data_w-1:0]  alu_shifted_i,
  output logic                       alu_shift_en_o,
  output logic [ex_pkg::clz_w-1:0]   alu_shift_amt_o,
  output logic [ex_pkg::data_w-1:0]  result_o,
  // Handshake
  input  logic                       valid_i,
  output logic                       ready_o,
  output logic                       valid_o,
  input  logic                       ready_i
);
  import ex_pkg::*;

  typedef enum logic [1:0] {IDLE, CLZ, DIVIDE, DONE} state_e;

  state_e            state_q;
  state_e            state_d;
  logic              is_signed;
  logic              a_neg;
  logic              b_neg;
  logic [data_w-1:0] a_abs;
  logic [data_w-1:0] b_abs;
  logic              div_zero;
  logic              overflow;
  logic              fits;
  logic [data_w-1:0] rem_q;
  logic [data_w-1:0] quot_q;
  logic [data_w-1:0] dvs_q;
  logic [clz_w-1:0]  cnt_q;
  logic              neg_quot_q;
  logic              neg_rem_q;
  logic              b_neg_q;
  logic              rem_sel_q;

  // Operand signs and magnitudes
  assign is_signed = (operator_i == DIV_S) || (operator_i == REM_S);
  assign a_neg     = is_signed && op_a_i[data_w-1];
  assign b_neg     = is_signed && op_b_i[data_w-1];
  assign a_abs     = a_neg ? -op_a_i : op_a_i;
  assign b_abs     = b_neg ? -op_b_i : op_b_i;
  // Both special cases finish straight from IDLE
  assign div_zero  = (op_b_i == '0);
  assign overflow  = is_signed && (op_a_i == {1'b1, {(data_w-1){1'b0}}}) && (op_b_i == '1);

  // Normalisation uses counter and shifter in the same cycle
  assign alu_clz_en_o    = (state_q == CLZ);
  assign alu_clz_data_o  = b_abs;
  assign alu_shift_en_o  = (state_q == CLZ);
  assign alu_shift_amt_o = alu_clz_result_i;

  assign fits    = (rem_q >= dvs_q);
  assign valid_o = (state_q == DONE);
  assign ready_o = (state_q == IDLE) || ((state_q == DONE) && ready_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (valid_i) begin
          state_d = (div_zero || overflow) ? DONE : CLZ;
        end
      end
      CLZ:    state_d = DIVIDE;
      DIVIDE: begin
        if (cnt_q == '0) begin
          state_d = DONE;
        end
      end
      default: begin
        if (ready_i) begin
          state_d = IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Quotient and remainder datapath
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    case (state_q)
      IDLE: begin
        if (valid_i) begin
          rem_sel_q  <= (operator_i == REM_S) || (operator_i == REM_U);
          b_neg_q    <= b_neg;
          neg_quot_q <= !div_zero && (a_neg ^ b_neg);
          neg_rem_q  <= !div_zero && a_neg;
          if (div_zero) begin
            // All ones, remainder keeps the dividend
            quot_q <= '1;
            rem_q  <= op_a_i;
          end else if (overflow) begin
            quot_q <= op_a_i;
            rem_q  <= '0;
          end else begin
            quot_q <= '0;
            rem_q  <= a_abs;
          end
        end
      end
      CLZ: begin
        // Shifted raw divisor, made positive again
        dvs_q <= b_neg_q ? -alu_shifted_i : alu_shifted_i;
        cnt_q <= alu_clz_result_i;
      end
      DIVIDE: begin
        quot_q <= {quot_q[data_w-2:0], fits};
        if (fits) begin
          rem_q <= rem_q - dvs_q;
        end
        dvs_q <= dvs_q >> 1;
        cnt_q <= cnt_q - 1'b1;
      end
      default: begin
        rem_q <= rem_q;
      end
    endcase
  end

  // Sign correction on the way out
  assign result_o = rem_sel_q ? (neg_rem_q ? -rem_q : rem_q)
                              : (neg_quot_q ? -quot_q : quot_q);

endmodule

//--- ex_mult.sv
//////////////////////////////////////////////////////////////////////
// Two-stage 32x32 multiplier, product registered in one stage
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module ex_mult (
  input  logic                       clk,
  input  logic                       rst_n,
  input  ex_pkg::mul_op_e            operator_i,
  input  logic [ex_pkg::data_w-1:0]  op_a_i,
  input  logic [ex_pkg::data_w-1:0]  op_b_i,
  output logic [ex_pkg::data_w-1:0]  result_o,
  // Handshake
  input  logic                       valid_i,
  output logic                       ready_o,
  output logic                       valid_o,
  input  logic                       ready_i
);
  import ex_pkg::*;

  logic                       signed_a;
  logic                       signed_b;
  logic signed [data_w:0]     a_ext;
  logic signed [data_w:0]     b_ext;
  logic signed [2*data_w+1:0] product;
  logic                       valid_q;
  logic                       high_q;
  logic [2*data_w-1:0]        product_q;

  // mulh is signed x signed, mulhsu signed x unsigned
  assign signed_a = (operator_i == MUL_HSS) || (operator_i == MUL_HSU);
  assign signed_b = (operator_i == MUL_HSS);
  assign a_ext    = {signed_a & op_a_i[data_w-1], op_a_i};
  assign b_ext    = {signed_b & op_b_i[data_w-1], op_b_i};
  assign product  = a_ext * b_ext;

  // Stage takes a new product when empty or when its result leaves
  assign ready_o = !valid_q || ready_i;
  assign valid_o = valid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      product_q <= product[2*data_w-1:0];
      high_q    <= (operator_i != MUL_LO);
    end
  end

  // Low word for mul, high word for the mulh variants
  assign result_o = high_q ? product_q[2*data_w-1:data_w] : product_q[data_w-1:0];

endmodule

//--- ex_alu.sv
//////////////////////////////////////////////////////////////////////
// Single-cycle ALU with one shared shifter and one comparator
// Counter and left-shift path are lent to the divider by side port
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module ex_alu (
  input  ex_pkg::alu_op_e            operator_i,
  input  logic [ex_pkg::data_w-1:0]  operand_a_i,
  input  logic [ex_pkg::data_w-1:0]  operand_b_i,
  // Leading-zero counter, divider side
  input  logic                       clz_en_i,
  input  logic [ex_pkg::data_w-1:0]  clz_data_i,
  output logic [ex_pkg::clz_w-1:0]   clz_result_o,
  // Left shift of operand a, divider side
  input  logic                       shift_en_i,
  input  logic [ex_pkg::clz_w-1:0]   shift_amt_i,
  output logic [ex_pkg::data_w-1:0]  shifted_o,
  output logic [ex_pkg::data_w-1:0]  result_o
);
  import ex_pkg::*;

  logic              sub_en;
  logic [data_w-1:0] adder_b;
  logic [data_w-1:0] sum;
  logic              cmp_signed;
  logic              less;
  logic              shift_left;
  logic              shift_arith;
  logic [clz_w-1:0]  shift_amt;
  logic [data_w-1:0] a_rev;
  logic [data_w-1:0] shift_in;
  logic [data_w:0]   shift_ext;
  logic [data_w-1:0] shift_right;
  logic [data_w-1:0] clz_in;

  // Adder, b inverted plus carry in for subtract
  assign sub_en  = (operator_i == ALU_SUB);
  assign adder_b = sub_en ? ~operand_b_i : operand_b_i;
  assign sum     = operand_a_i + adder_b + data_w'(sub_en);

  // One 33-bit comparator serves both slt and sltu
  assign cmp_signed = (operator_i == ALU_SLT);
  assign less = $signed({cmp_signed & operand_a_i[data_w-1], operand_a_i}) <
                $signed({cmp_signed & operand_b_i[data_w-1], operand_b_i});

  //////////////////////////////////////////////////////////////////////
  // Shared barrel shifter
  //////////////////////////////////////////////////////////////////////

  // Left shifts run through the right shifter on bit-reversed data
  assign shift_left  = shift_en_i || (operator_i == ALU_SLL);
  assign shift_arith = !shift_en_i && (operator_i == ALU_SRA);
  // Divider amount takes over while it owns the shifter
  assign shift_amt   = shift_en_i ? shift_amt_i : {1'b0, operand_b_i[clz_w-2:0]};
  assign a_rev       = {<<{operand_a_i}};
  assign shift_in    = shift_left ? a_rev : operand_a_i;
  assign shift_ext   = {shift_arith & shift_in[data_w-1], shift_in};
  assign shift_right = data_w'($signed(shift_ext) >>> shift_amt);
  assign shifted_o   = {<<{shift_right}};

  // Leading-zero counter, quiet unless the divider asks
  assign clz_in = clz_en_i ? clz_data_i : '0;

  always_comb begin
    clz_result_o = clz_w'(data_w);
    // Highest set bit wins, so scan upwards
    for (int i = 0; i < data_w; i++) begin
      if (clz_in[i]) begin
        clz_result_o = clz_w'(data_w - 1 - i);
      end
    end
  end

  // Result select
  always_comb begin
    case (operator_i)
      ALU_AND:           result_o = operand_a_i & operand_b_i;
      ALU_OR:            result_o = operand_a_i | operand_b_i;
      ALU_XOR:           result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:           result_o = shifted_o;
      ALU_SRL, ALU_SRA:  result_o = shift_right;
      ALU_SLT, ALU_SLTU: result_o = {{(data_w-1){1'b0}}, less};
      default:           result_o = sum;
    endcase
  end

endmodule

//--- ex_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared widths and opcode types of the execute subsystem
// Compiled ahead of every module that refers to it
//////////////////////////////////////////////////////////////////////
package ex_pkg;

  // Data path width, fixed by the instruction set
  localparam int unsigned data_w    = 32;
  // Opcode field common to all three units
  localparam int unsigned op_code_w = 4;
  // Leading-zero count and shift amount
  localparam int unsigned clz_w     = 6;

  // Functional unit select
  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_MUL = 2'd1,
    UNIT_DIV = 2'd2
  } unit_e;

  // ALU opcodes, full opcode field
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_e;

  // Multiplier opcodes, low two bits of the opcode field
  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,
    MUL_HSS = 2'd1,
    MUL_HSU = 2'd2,
    MUL_HUU = 2'd3
  } mul_op_e;

  // Divider opcodes, low two bits of the opcode field
  typedef enum logic [1:0] {
    DIV_S = 2'd0,
    DIV_U = 2'd1,
    REM_S = 2'd2,
    REM_U = 2'd3
  } div_op_e;

endpackage
